// ==== design/lsq_store_pkg.sv ====
`default_nettype none

package lsq_store_pkg;

  localparam int data_bytes     = 8;
  localparam int bank_bytes     = 4;
  localparam int bank_count     = 8;
  localparam int line_off_width = 5;
  localparam int addr_width     = 32;
  localparam int queue_depth    = 8;
  localparam int slot_count     = 16;
  localparam int slot_width     = 4;
  localparam int align_width    = 96;

  // 1, 2, 4 and 8 bytes
  typedef enum logic [1:0] {
    sz_byte  = 2'd0,
    sz_half  = 2'd1,
    sz_word  = 2'd2,
    sz_dword = 2'd3
  } store_size_e;

  typedef struct packed {
    logic [addr_width-1:0] addr;
    store_size_e           size;
    logic [slot_width-1:0] slot;
  } store_req_t;

  typedef struct packed {
    logic                    valid;
    logic [slot_width-1:0]   slot;
    logic [data_bytes*8-1:0] data;
  } store_data_wr_t;

  typedef struct packed {
    logic bus_hold;
    logic miss_hold;
    logic miss_pause;
    logic insert_data;
  } drain_hold_t;

  typedef struct packed {
    logic                   valid;
    logic [addr_width-1:0]  addr;
    logic [2:0]             end_bank;
    logic [bank_bytes-1:0]  bgn_ben;
    logic [bank_bytes-1:0]  end_ben;
    logic [align_width-1:0] data;
  } store_port_t;

  // last byte touched, relative to the begin bank (0..10)
  function automatic logic [3:0] end_byte(store_req_t req);
    logic [3:0] nbytes;
    case (req.size)
      sz_byte: nbytes = 4'd1;
      sz_half: nbytes = 4'd2;
      sz_word: nbytes = 4'd4;
      default: nbytes = 4'd8;
    endcase
    return {2'b00, req.addr[1:0]} + nbytes - 4'd1;
  endfunction

endpackage

`default_nettype wire

// ==== design/store_data_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_data_buffer (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  lsq_store_pkg::store_data_wr_t          data_wr,
  input  logic [lsq_store_pkg::slot_width-1:0]   rd_slot0,
  input  logic [lsq_store_pkg::slot_width-1:0]   rd_slot1,
  output logic                                   rd_ready0,
  output logic                                   rd_ready1,
  output logic [lsq_store_pkg::data_bytes*8-1:0] rd_data0,
  output logic [lsq_store_pkg::data_bytes*8-1:0] rd_data1,
  input  logic                                   release0,
  input  logic                                   release1,
  input  logic [lsq_store_pkg::slot_width-1:0]   release_slot0,
  input  logic [lsq_store_pkg::slot_width-1:0]   release_slot1
);

  logic [lsq_store_pkg::data_bytes*8-1:0] mem [lsq_store_pkg::slot_count];
  logic [lsq_store_pkg::slot_count-1:0]   ready;

  always_ff @(posedge clk) begin
    if (data_wr.valid) begin
      mem[data_wr.slot] <= data_wr.data;
    end
  end

  // releases first, a fresh write to the slot wins
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready <= '0;
    end else begin
      if (release0) begin
        ready[release_slot0] <= 1'b0;
      end
      if (release1) begin
        ready[release_slot1] <= 1'b0;
      end
      if (data_wr.valid) begin
        ready[data_wr.slot] <= 1'b1;
      end
    end
  end

  assign rd_ready0 = ready[rd_slot0];
  assign rd_ready1 = ready[rd_slot1];
  assign rd_data0  = mem[rd_slot0];
  assign rd_data1  = mem[rd_slot1];

  // slot must be drained before its data is rewritten
  a_wr_to_ready_slot: assert property (
    @(posedge clk) disable iff (!arst_n)
    data_wr.valid |-> !ready[data_wr.slot]
  ) else $error("data write to a slot that is still ready");

  a_release_distinct: assert property (
    @(posedge clk) disable iff (!arst_n)
    (release0 && release1) |-> (release_slot0 != release_slot1)
  ) else $error("both releases name the same slot");

endmodule

`default_nettype wire

// ==== design/store_req_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_req_queue (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic                                 push,
  input  lsq_store_pkg::store_req_t            push_req,
  input  lsq_store_pkg::drain_hold_t           hold,
  input  logic                                 st_stall,
  output logic                                 full,
  output logic [lsq_store_pkg::slot_width-1:0] rd_slot0,
  output logic [lsq_store_pkg::slot_width-1:0] rd_slot1,
  input  logic                                 rd_ready0,
  input  logic                                 rd_ready1,
  output logic                                 release0,
  output logic                                 release1,
  output logic [lsq_store_pkg::slot_width-1:0] release_slot0,
  output logic [lsq_store_pkg::slot_width-1:0] release_slot1,
  output logic                                 iss0_valid,
  output logic                                 iss1_valid,
  output lsq_store_pkg::store_req_t            iss0_req,
  output lsq_store_pkg::store_req_t            iss1_req
);

  lsq_store_pkg::store_req_t entries [lsq_store_pkg::queue_depth];

  logic [$clog2(lsq_store_pkg::queue_depth)-1:0] head;
  logic [$clog2(lsq_store_pkg::queue_depth)-1:0] head_nxt;
  logic [$clog2(lsq_store_pkg::queue_depth)-1:0] tail;
  logic [$clog2(lsq_store_pkg::queue_depth):0]   count;
  logic [$clog2(lsq_store_pkg::queue_depth):0]   count_nxt;
  logic                                          st_stall_q;
  logic                                          issue_block;
  logic [lsq_store_pkg::bank_count-1:0]          mask0;
  logic [lsq_store_pkg::bank_count-1:0]          mask1;

  // banks from begin bank through end bank, wrapping around the line
  function automatic logic [lsq_store_pkg::bank_count-1:0] bank_mask(
    lsq_store_pkg::store_req_t req
  );
    logic [3:0]                             eb;
    logic [lsq_store_pkg::bank_count-1:0]   span;
    logic [2*lsq_store_pkg::bank_count-1:0] rot;
    eb   = lsq_store_pkg::end_byte(req);
    span = '0;
    case (eb[3:2])
      2'd0:    span[0]   = 1'b1;
      2'd1:    span[1:0] = 2'b11;
      default: span[2:0] = 3'b111;
    endcase
    rot = {{lsq_store_pkg::bank_count{1'b0}}, span} << req.addr[4:2];
    return rot[lsq_store_pkg::bank_count-1:0] | rot[2*lsq_store_pkg::bank_count-1:
                                                    lsq_store_pkg::bank_count];
  endfunction

  assign full = (count == lsq_store_pkg::queue_depth);

  assign head_nxt = head + 1'b1;
  assign iss0_req = entries[head];
  assign iss1_req = entries[head_nxt];
  assign rd_slot0 = iss0_req.slot;
  assign rd_slot1 = iss1_req.slot;

  // stall is seen one cycle late, holds act at once
  assign issue_block = hold.bus_hold | hold.miss_hold | hold.miss_pause |
                       hold.insert_data | st_stall_q;

  assign mask0 = bank_mask(iss0_req);
  assign mask1 = bank_mask(iss1_req);

  assign iss0_valid = (count != '0) && rd_ready0 && !issue_block;
  assign iss1_valid = iss0_valid && (count > 1) && rd_ready1 && ((mask0 & mask1) == '0);

  assign release0      = iss0_valid;
  assign release1      = iss1_valid;
  assign release_slot0 = rd_slot0;
  assign release_slot1 = rd_slot1;

  always_comb begin
    count_nxt = count;
    if (push) begin
      count_nxt = count_nxt + 1'b1;
    end
    if (iss0_valid) begin
      count_nxt = count_nxt - 1'b1;
    end
    if (iss1_valid) begin
      count_nxt = count_nxt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[tail] <= push_req;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      st_stall_q <= 1'b0;
    end else begin
      st_stall_q <= st_stall;
      count      <= count_nxt;
      if (push) begin
        tail <= tail + 1'b1;
      end
      if (iss1_valid) begin
        head <= head_nxt + 1'b1;
      end else if (iss0_valid) begin
        head <= head_nxt;
      end
    end
  end

  a_push_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    push |-> !full
  ) else $error("store pushed while queue is full");

  a_port1_alone: assert property (
    @(posedge clk) disable iff (!arst_n)
    iss1_valid |-> iss0_valid
  ) else $error("port 1 issued without port 0");

endmodule

`default_nettype wire

// ==== design/store_port_format.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_port_format (
  input  logic                                   clk,
  input  logic                                   arst_n,
  input  logic                                   iss_valid,
  input  lsq_store_pkg::store_req_t              iss_req,
  input  logic [lsq_store_pkg::data_bytes*8-1:0] iss_data,
  output lsq_store_pkg::store_port_t             port
);

  logic [1:0]                              low;
  logic [3:0]                              eb;
  logic [2:0]                              bgn_bank;
  logic [2:0]                              end_bank;
  logic [lsq_store_pkg::bank_bytes-1:0]    low_mask;
  logic [lsq_store_pkg::bank_bytes-1:0]    high_mask;
  logic [lsq_store_pkg::bank_bytes-1:0]    bgn_ben;
  logic [lsq_store_pkg::bank_bytes-1:0]    end_ben;
  logic [lsq_store_pkg::data_bytes-1:0]    byte_en;
  logic [lsq_store_pkg::data_bytes*8-1:0]  masked;
  logic [lsq_store_pkg::align_width-1:0]   aligned;

  assign low      = iss_req.addr[1:0];
  assign bgn_bank = iss_req.addr[lsq_store_pkg::line_off_width-1:2];
  assign eb       = lsq_store_pkg::end_byte(iss_req);
  assign end_bank = bgn_bank + {1'b0, eb[3:2]};

  // bytes at or above the offset, bytes at or below the last byte
  assign low_mask = 4'hf << low;

  always_comb begin
    case (eb[1:0])
      2'd0:    high_mask = 4'b0001;
      2'd1:    high_mask = 4'b0011;
      2'd2:    high_mask = 4'b0111;
      default: high_mask = 4'b1111;
    endcase
  end

  assign bgn_ben = (eb[3:2] == 2'd0) ? (low_mask & high_mask) : low_mask;
  assign end_ben = (eb[3:2] == 2'd0) ? (low_mask & high_mask) : high_mask;

  always_comb begin
    case (iss_req.size)
      lsq_store_pkg::sz_byte: byte_en = 8'h01;
      lsq_store_pkg::sz_half: byte_en = 8'h03;
      lsq_store_pkg::sz_word: byte_en = 8'h0f;
      default:                byte_en = 8'hff;
    endcase
  end

  always_comb begin
    for (int b = 0; b < lsq_store_pkg::data_bytes; b++) begin
      masked[b*8 +: 8] = byte_en[b] ? iss_data[b*8 +: 8] : 8'h00;
    end
  end

  assign aligned = {{(lsq_store_pkg::align_width - lsq_store_pkg::data_bytes*8){1'b0}},
                    masked} << {low, 3'b000};

  // payload loads only on issue
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      port.valid <= 1'b0;
    end else begin
      port.valid <= iss_valid;
      if (iss_valid) begin
        port.addr     <= iss_req.addr;
        port.end_bank <= end_bank;
        port.bgn_ben  <= bgn_ben;
        port.end_ben  <= end_ben;
        port.data     <= aligned;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/store_drain_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_drain_top (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         push,
  input  lsq_store_pkg::store_req_t    push_req,
  input  lsq_store_pkg::store_data_wr_t data_wr,
  input  lsq_store_pkg::drain_hold_t   hold,
  input  logic                         st_stall,
  output logic                         full,
  output lsq_store_pkg::store_port_t   st0,
  output lsq_store_pkg::store_port_t   st1
);

  logic [lsq_store_pkg::slot_width-1:0]   rd_slot0;
  logic [lsq_store_pkg::slot_width-1:0]   rd_slot1;
  logic                                   rd_ready0;
  logic                                   rd_ready1;
  logic [lsq_store_pkg::data_bytes*8-1:0] rd_data0;
  logic [lsq_store_pkg::data_bytes*8-1:0] rd_data1;
  logic                                   release0;
  logic                                   release1;
  logic [lsq_store_pkg::slot_width-1:0]   release_slot0;
  logic [lsq_store_pkg::slot_width-1:0]   release_slot1;
  logic                                   iss0_valid;
  logic                                   iss1_valid;
  lsq_store_pkg::store_req_t              iss0_req;
  lsq_store_pkg::store_req_t              iss1_req;

  store_data_buffer i_data_buffer (
    .clk           (clk),
    .arst_n        (arst_n),
    .data_wr       (data_wr),
    .rd_slot0      (rd_slot0),
    .rd_slot1      (rd_slot1),
    .rd_ready0     (rd_ready0),
    .rd_ready1     (rd_ready1),
    .rd_data0      (rd_data0),
    .rd_data1      (rd_data1),
    .release0      (release0),
    .release1      (release1),
    .release_slot0 (release_slot0),
    .release_slot1 (release_slot1)
  );

  store_req_queue i_req_queue (
    .clk           (clk),
    .arst_n        (arst_n),
    .push          (push),
    .push_req      (push_req),
    .hold          (hold),
    .st_stall      (st_stall),
    .full          (full),
    .rd_slot0      (rd_slot0),
    .rd_slot1      (rd_slot1),
    .rd_ready0     (rd_ready0),
    .rd_ready1     (rd_ready1),
    .release0      (release0),
    .release1      (release1),
    .release_slot0 (release_slot0),
    .release_slot1 (release_slot1),
    .iss0_valid    (iss0_valid),
    .iss1_valid    (iss1_valid),
    .iss0_req      (iss0_req),
    .iss1_req      (iss1_req)
  );

  // port 0 always carries the older store
  store_port_format i_port0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .iss_valid (iss0_valid),
    .iss_req   (iss0_req),
    .iss_data  (rd_data0),
    .port      (st0)
  );

  store_port_format i_port1 (
    .clk       (clk),
    .arst_n    (arst_n),
    .iss_valid (iss1_valid),
    .iss_req   (iss1_req),
    .iss_data  (rd_data1),
    .port      (st1)
  );

endmodule

`default_nettype wire

// ==== dv/store_drain_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_drain_tb;

  logic                          clk = 1'b0;
  logic                          arst_n;
  logic                          push;
  lsq_store_pkg::store_req_t     push_req;
  lsq_store_pkg::store_data_wr_t data_wr;
  lsq_store_pkg::drain_hold_t    hold;
  logic                          st_stall;
  logic                          full;
  lsq_store_pkg::store_port_t    st0;
  lsq_store_pkg::store_port_t    st1;

  // stores pushed but not yet seen on a port, oldest first
  lsq_store_pkg::store_port_t exp_q[$];

  int   stall_left  = 0;
  int   cycle_count = 0;
  int   cycle_limit = 0;
  logic stall_d1    = 1'b0;
  logic stall_d2    = 1'b0;
  logic hold_d1     = 1'b0;
  logic saw_full    = 1'b0;
  logic saw_dual    = 1'b0;

  store_drain_top i_store_drain_top (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (push),
    .push_req (push_req),
    .data_wr  (data_wr),
    .hold     (hold),
    .st_stall (st_stall),
    .full     (full),
    .st0      (st0),
    .st1      (st1)
  );

  always #20 clk = ~clk;

  // stall acts one cycle late, hold at once, port shows up one cycle after issue
  always @(posedge clk) begin
    stall_d2 <= stall_d1;
    stall_d1 <= st_stall;
    hold_d1  <= (hold != '0);
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: store drain never completed within %0d cycles", cycle_limit);
      stop_run();
    end
  end

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_port(input int idx, input lsq_store_pkg::store_port_t got,
                            input lsq_store_pkg::store_port_t want);
    if (got !== want) begin
      $display("FAIL %0t: port %0d addr %h bank %0d ben %h/%h data %h", $time, idx,
               got.addr, got.end_bank, got.bgn_ben, got.end_ben, got.data);
      $display("FAIL %0t: expected addr %h bank %0d ben %h/%h data %h", $time,
               want.addr, want.end_bank, want.bgn_ben, want.end_ben, want.data);
      stop_run();
    end
  endtask

  task automatic check_full(input logic got, input logic want);
    if (got !== want) begin
      $display("FAIL %0t: full is %b, expected %b with %0d stores queued", $time,
               got, want, exp_q.size());
      stop_run();
    end
  endtask

  // begin bank up to last bank, wrapping around the line
  function automatic logic [7:0] banks_touched(input logic [31:0] addr,
                                               input logic [2:0] last);
    logic [7:0] mask;
    logic [2:0] b;
    mask    = '0;
    b       = addr[4:2];
    mask[b] = 1'b1;
    while (b != last) begin
      b       = b + 3'd1;
      mask[b] = 1'b1;
    end
    return mask;
  endfunction

  task automatic sample_ports();
    lsq_store_pkg::store_port_t exp0;
    lsq_store_pkg::store_port_t exp1;
    if ((st0.valid || st1.valid) && (hold_d1 || stall_d2)) begin
      $display("store left at %0t although the issue cycle was held or stalled", $time);
      stop_run();
    end
    if (st1.valid && !st0.valid) begin
      $display("port 1 carried a store at %0t while port 0 was idle", $time);
      stop_run();
    end
    if (st0.valid) begin
      if (exp_q.size() == 0) begin
        $display("store appeared on port 0 at %0t with none outstanding", $time);
        stop_run();
      end else begin
        exp0 = exp_q.pop_front();
        check_port(0, st0, exp0);
      end
    end
    if (st1.valid) begin
      saw_dual = 1'b1;
      if (exp_q.size() == 0) begin
        $display("store appeared on port 1 at %0t with none outstanding", $time);
        stop_run();
      end else begin
        exp1 = exp_q.pop_front();
        check_port(1, st1, exp1);
        if ((banks_touched(exp0.addr, exp0.end_bank) &
             banks_touched(exp1.addr, exp1.end_bank)) != '0) begin
          $display("stores with overlapping banks issued together at %0t", $time);
          stop_run();
        end
      end
    end
    check_full(full, exp_q.size() == lsq_store_pkg::queue_depth);
    if (full) begin
      saw_full = 1'b1;
    end
  endtask

  // check outputs, then clear the strobes for the new cycle
  task automatic next_cycle();
    @(negedge clk);
    sample_ports();
    push          = 1'b0;
    data_wr.valid = 1'b0;
    hold          = '0;
    st_stall      = (stall_left > 0);
    if (stall_left > 0) begin
      stall_left--;
    end
  endtask

  initial begin
    int                         fd;
    int                         code;
    int                         line_count;
    int                         size;
    int                         cycles;
    string                      cmd;
    string                      line;
    logic [31:0]                addr;
    logic [3:0]                 slot;
    logic [2:0]                 last_bank;
    logic [3:0]                 bgn_ben;
    logic [3:0]                 end_ben;
    logic [95:0]                aligned;
    logic [63:0]                word;
    lsq_store_pkg::store_port_t want;

    void'($urandom(85));
    arst_n     = 1'b0;
    push       = 1'b0;
    push_req   = '0;
    data_wr    = '0;
    hold       = '0;
    st_stall   = 1'b0;
    line_count = 0;

    fd = $fopen("dv/store_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/store_patterns.txt");
      stop_run();
    end
    while ($fgets(line, fd) != 0) begin
      line_count++;
    end
    $fclose(fd);
    cycle_limit = 20 * line_count + 200;

    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    fd   = $fopen("dv/store_patterns.txt", "r");
    code = $fscanf(fd, "%s", cmd);
    while (code == 1) begin
      if (cmd == "#") begin
        code = $fgets(line, fd);
      end else if (cmd == "push") begin
        code = $fscanf(fd, "%h %d %h %h %h %h %h", addr, size, slot, last_bank,
                       bgn_ben, end_ben, aligned);
        next_cycle();
        push          = 1'b1;
        push_req.addr = addr;
        push_req.size = lsq_store_pkg::store_size_e'(size);
        push_req.slot = slot;
        want.valid    = 1'b1;
        want.addr     = addr;
        want.end_bank = last_bank;
        want.bgn_ben  = bgn_ben;
        want.end_ben  = end_ben;
        want.data     = aligned;
        exp_q.push_back(want);
      end else if (cmd == "data") begin
        code = $fscanf(fd, "%h %h", slot, word);
        next_cycle();
        data_wr.valid = 1'b1;
        data_wr.slot  = slot;
        data_wr.data  = word;
      end else if (cmd == "stall") begin
        code       = $fscanf(fd, "%d", cycles);
        stall_left = cycles;
      end else begin
        $display("unknown command %s in pattern file", cmd);
        stop_run();
      end
      // occasional one-cycle hold between commands
      if (cmd != "#" && $urandom % 4 == 0) begin
        next_cycle();
        hold = lsq_store_pkg::drain_hold_t'(4'b0001 << ($urandom % 4));
      end
      code = $fscanf(fd, "%s", cmd);
    end
    $fclose(fd);

    while (exp_q.size() != 0) begin
      next_cycle();
    end
    repeat (4) next_cycle();

    if (!saw_full || !saw_dual) begin
      $display("run ended without a full queue or without a dual issue");
      stop_run();
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sim.f ====
design/lsq_store_pkg.sv
design/store_data_buffer.sv
design/store_req_queue.sv
design/store_port_format.sv
design/store_drain_top.sv
dv/store_drain_tb.sv

// ==== dv/store_patterns.txt ====
# push <addr> <size 0-3> <slot> <end_bank> <bgn_ben> <end_ben> <aligned data, 96 bits>
# data <slot> <word>, stall <cycles>; all values hex except size and cycles
data 0 8877665544332211
data 1 8877665544332211
data 2 8877665544332211
data 3 8877665544332211
data 4 8877665544332211
data 5 8877665544332211
push 00000107 0 0 1 8 8 000000000000000011000000
push 00000113 1 1 5 8 1 000000000000002211000000
push 0000011d 2 2 0 e 1 000000000000004433221100
push 00000120 3 3 1 f f 000000008877665544332211
push 0000010e 3 4 5 c 3 000088776655443322110000
push 0000111f 3 5 1 8 7 008877665544332211000000
data a 8877665544332211
data b 8877665544332211
push 00000200 2 9 0 f f 0000000000000000deadbeef
push 00000204 2 a 1 f f 000000000000000044332211
push 00000208 2 b 2 f f 000000000000000044332211
data 9 12345678deadbeef
push 0000020c 2 c 3 f f 000000000000000055667788
push 0000020e 1 d 3 c c 000000000000000077880000
data d 1122334455667788
data c 1122334455667788
stall 5
data e 0123456789abcdef
data f fedcba9876543210
push 00000300 3 e 1 f f 000000000123456789abcdef
push 00000310 3 f 5 f f 00000000fedcba9876543210
push 00000400 2 0 0 f f 0000000000000000aaaaaa00
push 00000404 2 1 1 f f 0000000000000000aaaaaa01
push 00000408 2 2 2 f f 0000000000000000aaaaaa02
push 0000040c 2 3 3 f f 0000000000000000aaaaaa03
push 00000410 2 4 4 f f 0000000000000000aaaaaa04
push 00000414 2 5 5 f f 0000000000000000aaaaaa05
push 00000418 2 6 6 f f 0000000000000000aaaaaa06
push 0000041c 2 7 7 f f 0000000000000000aaaaaa07
data 7 ccccccccaaaaaa07
data 6 ccccccccaaaaaa06
data 5 ccccccccaaaaaa05
data 4 ccccccccaaaaaa04
data 3 ccccccccaaaaaa03
data 2 ccccccccaaaaaa02
data 1 ccccccccaaaaaa01
data 0 ccccccccaaaaaa00
